//--- sources.f
+incdir+verilog
+incdir+test
verilog/codecPkg.sv
verilog/totalDivider.sv
verilog/intervalUpdate.sv
verilog/renormalizer.sv
verilog/outputPacker.sv
verilog/arithEncoder.sv
test/tbArithEncoder.sv

//--- test/encoderRefModel.svh
// behavioural reference encoder for the fixed 17-symbol model, builds expected code words
`ifndef ENCODER_REF_MODEL_SVH
`define ENCODER_REF_MODEL_SVH

logic [31:0] refWord;       // word being filled, lsb first
int          refBitPos;
int          refPending;    // deferred opposite bits

task automatic pushRefBit(input logic value, input logic closing);
    refWord[refBitPos] = value;
    refBitPos++;
    if (refBitPos == `WORD_BITS || closing) begin
        expWords.push_back(refWord);
        expBytes.push_back((refBitPos + 7) / 8);    // bytes with at least one bit
        refWord = '0;
        refBitPos = 0;
    end
endtask

// one decided bit followed by the deferred opposite bits
task automatic emitWithPending(input logic value, input logic finalRun);
    pushRefBit(value, finalRun && refPending == 0);
    for (int j = 0; j < refPending; j++) begin
        pushRefBit(!value, finalRun && j == refPending - 1);
    end
    refPending = 0;
endtask

task automatic encodeReference();
    longint low;
    longint high;
    longint width;
    longint cumBegin;
    longint cumEnd;
    int     sym;
    bit     expanding;
    expWords.delete();
    expBytes.delete();
    refWord = '0;
    refBitPos = 0;
    refPending = 0;
    low = 0;
    high = `CODEC_WHOLE;
    foreach (msgSymbols[i]) begin
        sym = msgSymbols[i];
        width = high - low;
        cumBegin = sym * (sym + 1) / 2;    // sum of frequencies 1..k
        cumEnd = (sym == `EOF_SYMBOL) ? `FREQ_TOTAL : cumBegin + sym + 1;
        high = low + width * cumEnd / `FREQ_TOTAL;
        low = low + width * cumBegin / `FREQ_TOTAL;
        expanding = 1'b1;
        while (expanding) begin
            if (high < `CODEC_HALF) begin
                emitWithPending(1'b0, 1'b0);
                low = low * 2;
                high = high * 2;
            end else if (low > `CODEC_HALF) begin
                emitWithPending(1'b1, 1'b0);
                low = (low - `CODEC_HALF) * 2;
                high = (high - `CODEC_HALF) * 2;
            end else if (low > `CODEC_QUARTER && high < `CODEC_THREE_QUARTERS) begin
                refPending++;
                low = (low - `CODEC_QUARTER) * 2;
                high = (high - `CODEC_QUARTER) * 2;
            end else begin
                expanding = 1'b0;
            end
        end
        if (sym == `EOF_SYMBOL) begin
            refPending++;    // termination picks the quarter the interval covers
            emitWithPending(low > `CODEC_QUARTER, 1'b1);
        end
    end
endtask

`endif

//--- test/tbArithEncoder.sv
// testbench that runs directed tests of the streaming arithmetic encoder against a reference model
`timescale 1ns/100ps
`include "codec_defs.svh"

module tbArithEncoder;

    import codecPkg::*;

    localparam int cycleLimit = 40000;

    logic        clk;
    logic        rstn;
    logic        start;
    logic        symbolProvided;
    logic        readAck;
    symbolT      symbolIn;
    logic        idle;
    logic        symbolRequest;
    logic        resultReady;
    logic [31:0] codeWord;
    logic [2:0]  validOutputBytes;

    logic [31:0] lfsrState;
    int          msgSymbols[$];
    logic [31:0] expWords[$];
    int          expBytes[$];
    logic [31:0] gotWords[$];
    int          gotBytes[$];
    int          requestCount;

    `include "encoderRefModel.svh"

    arithEncoder DUT (
        .clk(clk), .rstn(rstn), .start(start), .symbolProvided(symbolProvided),
        .readAck(readAck), .symbolIn(symbolIn), .idle(idle), .symbolRequest(symbolRequest),
        .resultReady(resultReady), .codeWord(codeWord), .validOutputBytes(validOutputBytes)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'hB4BCD35C) : (state >> 1);    // galois step with maximal taps
    endfunction

    task automatic drawBits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | lfsrState[0];
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compareValues(input string testName, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            failRun($sformatf("MISMATCH %s expected 0x%08h actual 0x%08h",
                              testName, expected, actual));
        end
    endtask

    // plays the host by starting the message, answering requests and acknowledging words
    task automatic runMessage(input string testName, input bit randomDelay);
        int   cycles;
        int   nextIndex;
        int   ackDelay;
        bit   waitingAck;
        bit   finished;
        logic nextAck;
        logic nextProvided;
        int   nextSymbol;
        cycles = 0;
        nextIndex = 1;
        ackDelay = 0;
        waitingAck = 1'b0;
        finished = 1'b0;
        nextSymbol = 0;
        requestCount = 0;
        gotWords.delete();
        gotBytes.delete();
        @(negedge clk);
        while (!idle) begin
            cycles++;
            if (cycles > cycleLimit) failRun($sformatf("%s: encoder never became idle", testName));
            @(negedge clk);
        end
        @(posedge clk);
        start <= 1'b1;
        symbolIn <= symbolT'(msgSymbols[0]);
        @(posedge clk);
        start <= 1'b0;
        cycles = 0;
        while (!finished) begin
            @(negedge clk);    // outputs settled here
            cycles++;
            if (cycles > cycleLimit) begin
                failRun($sformatf("%s: timeout waiting for the message to finish", testName));
            end
            nextAck = readAck;
            nextProvided = symbolProvided;
            if (readAck && !resultReady) begin
                nextAck = 1'b0;
            end else if (!readAck && resultReady) begin
                if (!waitingAck) begin
                    waitingAck = 1'b1;
                    ackDelay = 0;
                    if (randomDelay) drawBits(3, ackDelay);
                end
                if (ackDelay == 0) begin
                    gotWords.push_back(codeWord);
                    gotBytes.push_back(validOutputBytes);
                    nextAck = 1'b1;
                    waitingAck = 1'b0;
                end else begin
                    ackDelay--;
                end
            end
            if (symbolProvided && !symbolRequest) begin
                nextProvided = 1'b0;
            end else if (!symbolProvided && symbolRequest) begin
                if (nextIndex >= msgSymbols.size()) begin
                    failRun($sformatf("%s: symbol requested after the end of message", testName));
                end
                nextSymbol = msgSymbols[nextIndex];
                nextIndex++;
                requestCount++;
                nextProvided = 1'b1;
            end
            finished = idle && !readAck && !resultReady;
            @(posedge clk);
            readAck <= nextAck;
            symbolProvided <= nextProvided;
            symbolIn <= symbolT'(nextSymbol);
        end
    endtask

    task automatic checkWords(input string testName);
        encodeReference();
        compareValues({testName, " word count"}, expWords.size(), gotWords.size());
        foreach (expWords[i]) begin
            compareValues($sformatf("%s word %0d", testName, i), expWords[i], gotWords[i]);
            compareValues($sformatf("%s bytes %0d", testName, i), expBytes[i], gotBytes[i]);
        end
        compareValues({testName, " requests"}, msgSymbols.size() - 1, requestCount);
    endtask

    task automatic resetStateTest();
        @(negedge clk);
        compareValues("reset idle", 1, idle);
        compareValues("reset resultReady", 0, resultReady);
        compareValues("reset symbolRequest", 0, symbolRequest);
    endtask

    task automatic eofOnlyTest();
        msgSymbols.delete();
        msgSymbols.push_back(`EOF_SYMBOL);
        runMessage("eof only", 1'b0);
        checkWords("eof only");
    endtask

    task automatic fixedMessageTest();
        msgSymbols.delete();
        msgSymbols.push_back(3);
        msgSymbols.push_back(15);
        msgSymbols.push_back(0);
        msgSymbols.push_back(9);
        msgSymbols.push_back(12);
        msgSymbols.push_back(`EOF_SYMBOL);
        runMessage("fixed message", 1'b0);
        checkWords("fixed message");
    endtask

    task automatic longMessageTest();
        int value;
        msgSymbols.delete();
        for (int i = 0; i < 60; i++) begin
            drawBits(4, value);
            msgSymbols.push_back(value);
        end
        msgSymbols.push_back(`EOF_SYMBOL);
        runMessage("long message", 1'b1);
        checkWords("long message");
        for (int i = 0; i < gotBytes.size() - 1; i++) begin
            compareValues($sformatf("long message full word %0d", i), 4, gotBytes[i]);
        end
    endtask

    task automatic backToBackTest();
        msgSymbols.delete();
        msgSymbols.push_back(5);
        msgSymbols.push_back(1);
        msgSymbols.push_back(14);
        msgSymbols.push_back(`EOF_SYMBOL);
        runMessage("first message", 1'b0);
        checkWords("first message");
        msgSymbols.delete();
        msgSymbols.push_back(0);
        msgSymbols.push_back(0);
        msgSymbols.push_back(15);
        msgSymbols.push_back(2);
        msgSymbols.push_back(`EOF_SYMBOL);
        runMessage("second message", 1'b1);    // must not depend on the first one
        checkWords("second message");
    endtask

    initial begin
        rstn = 1'b0;
        start = 1'b0;
        symbolProvided = 1'b0;
        readAck = 1'b0;
        symbolIn = '0;
        lfsrState = 32'h55911925;
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        resetStateTest();
        eofOnlyTest();
        fixedMessageTest();
        longMessageTest();
        backToBackTest();
        $display("Test passed");
        $finish;
    end

endmodule

//--- verilog/arithEncoder.sv
// streaming arithmetic encoder top, symbol intake FSM around update, renormalize and pack
`timescale 1ns/100ps
`include "codec_defs.svh"

module arithEncoder (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  start,
    input  logic                  symbolProvided,
    input  logic                  readAck,
    input  codecPkg::symbolT      symbolIn,
    output logic                  idle,
    output logic                  symbolRequest,
    output logic                  resultReady,
    output logic [`WORD_BITS-1:0] codeWord,
    output logic [2:0]            validOutputBytes
);

    import codecPkg::*;

    localparam logic [`CODEC_PRECISION-1:0] wholeBound = `CODEC_WHOLE;

    encStateT state;
    symbolT   curSymbol;
    intervalT interval;
    intervalT narrowed;
    intervalT rescaled;
    codeBitT  codeBit;
    logic     updStart;
    logic     updDone;
    logic     rnStart;
    logic     rnDone;
    logic     finalFlush;
    logic     lastBit;
    logic     packerFull;

    assign finalFlush = (curSymbol == `EOF_SYMBOL);
    assign idle = (state == ENC_IDLE);
    assign symbolRequest = (state == ENC_REQUEST);

    intervalUpdate update (
        .clk(clk), .rstn(rstn), .updStart(updStart), .symbol(curSymbol),
        .curInterval(interval), .updDone(updDone), .newInterval(narrowed)
    );

    renormalizer renorm (
        .clk(clk), .rstn(rstn), .rnStart(rnStart), .finalFlush(finalFlush),
        .inInterval(interval), .packerFull(packerFull), .rnDone(rnDone),
        .outInterval(rescaled), .codeBit(codeBit), .lastBit(lastBit)
    );

    outputPacker packer (
        .clk(clk), .rstn(rstn), .codeBit(codeBit), .lastBit(lastBit), .readAck(readAck),
        .packerFull(packerFull), .resultReady(resultReady), .codeWord(codeWord),
        .validOutputBytes(validOutputBytes)
    );

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= ENC_IDLE;
            updStart <= 1'b0;
            rnStart <= 1'b0;
        end else begin
            updStart <= 1'b0;
            rnStart <= 1'b0;
            case (state)
                ENC_IDLE: if (start) begin
                    updStart <= 1'b1;
                    state <= ENC_UPDATE;
                end
                ENC_UPDATE: if (updDone) begin
                    rnStart <= 1'b1;
                    state <= ENC_RENORM;
                end
                ENC_RENORM: if (rnDone) state <= finalFlush ? ENC_FINISH : ENC_REQUEST;
                ENC_REQUEST: if (symbolProvided) state <= ENC_WAIT_DROP;
                ENC_WAIT_DROP: if (!symbolProvided) begin
                    updStart <= 1'b1;
                    state <= ENC_UPDATE;
                end
                ENC_FINISH: if (!packerFull) state <= ENC_IDLE;    // last word read
                default: state <= ENC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ENC_IDLE && start) begin
            curSymbol <= symbolIn;
            interval.high <= wholeBound;    // every message starts from the full range
            interval.low <= '0;
        end
        if (state == ENC_REQUEST && symbolProvided) curSymbol <= symbolIn;
        if (state == ENC_UPDATE && updDone) interval <= narrowed;
        if (state == ENC_RENORM && rnDone) interval <= rescaled;
    end

endmodule

//--- verilog/outputPacker.sv
// packs emitted code bits into 32-bit words and runs the read acknowledge
`timescale 1ns/100ps
`include "codec_defs.svh"

module outputPacker (
    input  logic                  clk,
    input  logic                  rstn,
    input  codecPkg::codeBitT     codeBit,
    input  logic                  lastBit,
    input  logic                  readAck,
    output logic                  packerFull,
    output logic                  resultReady,
    output logic [`WORD_BITS-1:0] codeWord,
    output logic [2:0]            validOutputBytes
);

    localparam int ptrWidth = $clog2(`WORD_BITS);

    logic [ptrWidth-1:0] bitPtr;       // next free bit, lsb first
    logic [ptrWidth-4:0] byteIndex;
    logic                wordClosing;

    assign byteIndex = bitPtr[ptrWidth-1:3];
    assign wordClosing = codeBit.valid && (lastBit || bitPtr == ptrWidth'(`WORD_BITS - 1));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            bitPtr <= '0;
            codeWord <= '0;
            resultReady <= 1'b0;
            packerFull <= 1'b0;
            validOutputBytes <= '0;
        end else begin
            if (codeBit.valid) begin
                codeWord[bitPtr] <= codeBit.value;
                bitPtr <= bitPtr + 1'b1;
            end
            if (wordClosing) begin
                resultReady <= 1'b1;
                packerFull <= 1'b1;
                validOutputBytes <= 3'(byteIndex) + 3'd1;    // bytes touched so far
            end
            if (resultReady && readAck) begin
                resultReady <= 1'b0;
                codeWord <= '0;
                bitPtr <= '0;
            end else if (packerFull && !resultReady && !readAck) begin
                packerFull <= 1'b0;    // host has dropped its acknowledge
            end
        end
    end

    // the renormalizer must see packerFull before it strobes
    assert property (@(posedge clk) disable iff (!rstn) codeBit.valid |-> !packerFull)
        else $error("code bit strobed into a full word");

endmodule

//--- verilog/renormalizer.sv
// interval expansion with pending-bit tracking and termination bit emission
`timescale 1ns/100ps
`include "codec_defs.svh"

module renormalizer (
    input  logic               clk,
    input  logic               rstn,
    input  logic               rnStart,
    input  logic               finalFlush,
    input  codecPkg::intervalT inInterval,
    input  logic               packerFull,
    output logic               rnDone,
    output codecPkg::intervalT outInterval,
    output codecPkg::codeBitT  codeBit,
    output logic               lastBit
);

    import codecPkg::*;

    localparam logic [`CODEC_PRECISION-1:0] halfBound = `CODEC_HALF;
    localparam logic [`CODEC_PRECISION-1:0] quarterBound = `CODEC_QUARTER;
    localparam logic [`CODEC_PRECISION-1:0] threeQuarterBound = `CODEC_THREE_QUARTERS;

    renormStateT                 state;
    logic [`CODEC_PRECISION-1:0] low;
    logic [`CODEC_PRECISION-1:0] high;
    logic [`PENDING_WIDTH-1:0]   pending;
    logic                        pendingValue;    // opposite of the last emitted bit
    logic                        flushing;
    logic                        isLeft;
    logic                        isRight;
    logic                        isMiddle;
    logic                        isStop;
    logic                        sendBit;
    logic                        bitValue;
    logic                        bumpPending;

    assign isLeft = high < halfBound;
    assign isRight = !isLeft && (low > halfBound);
    assign isMiddle = !isLeft && !isRight && (low > quarterBound) && (high < threeQuarterBound);
    assign isStop = !isLeft && !isRight && !isMiddle;

    always_comb begin
        sendBit = 1'b0;
        bitValue = pendingValue;
        case (state)
            RN_DECIDE: begin
                sendBit = isLeft || isRight || (isStop && flushing);
                bitValue = isLeft ? 1'b0 : isRight ? 1'b1 : (low > quarterBound);
            end
            RN_PENDING, RN_DRAIN: sendBit = 1'b1;
            default: sendBit = 1'b0;
        endcase
    end

    assign codeBit.valid = sendBit && !packerFull;    // hold while the word is out
    assign codeBit.value = bitValue;
    assign lastBit = codeBit.valid && (state == RN_DRAIN) && (pending == 1);
    assign rnDone = (state == RN_DECIDE && isStop && !flushing) || lastBit;
    assign bumpPending = (state == RN_DECIDE) && (isMiddle || (isStop && flushing && !packerFull));
    assign outInterval.high = high;
    assign outInterval.low = low;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= RN_IDLE;
            pending <= '0;
            pendingValue <= 1'b0;
            flushing <= 1'b0;
        end else begin
            if (bumpPending) begin
                pending <= pending + 1'b1;
            end else if (state != RN_DECIDE && codeBit.valid) begin
                pending <= pending - 1'b1;
            end
            case (state)
                RN_IDLE: begin
                    if (rnStart) begin
                        flushing <= finalFlush;
                        state <= RN_DECIDE;
                    end
                end
                RN_DECIDE: begin
                    if (codeBit.valid) begin
                        pendingValue <= !bitValue;
                        if (isStop) begin
                            state <= RN_DRAIN;    // termination, pending now at least one
                        end else if (pending != 0) begin
                            state <= RN_PENDING;
                        end
                    end else if (isStop && !flushing) begin
                        state <= RN_IDLE;
                    end
                end
                RN_PENDING: begin
                    if (codeBit.valid && pending == 1) begin
                        state <= RN_DECIDE;
                    end
                end
                default: begin
                    if (lastBit) begin
                        state <= RN_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RN_IDLE && rnStart) begin
            low <= inInterval.low;
            high <= inInterval.high;
        end else if (state == RN_DECIDE && (codeBit.valid || isMiddle) && !isStop) begin
            if (isLeft) begin
                low <= low << 1;
                high <= high << 1;
            end else if (isRight) begin
                low <= (low - halfBound) << 1;
                high <= (high - halfBound) << 1;
            end else begin
                low <= (low - quarterBound) << 1;
                high <= (high - quarterBound) << 1;
            end
        end
    end

    // a wrap would silently drop the deferred bits
    assert property (@(posedge clk) disable iff (!rstn) bumpPending |=> pending != '0)
        else $error("pending bit counter wrapped");

endmodule

//--- verilog/intervalUpdate.sv
// narrows the coding interval to the subrange of one symbol of the fixed model
`timescale 1ns/100ps
`include "codec_defs.svh"

module intervalUpdate (
    input  logic               clk,
    input  logic               rstn,
    input  logic               updStart,
    input  codecPkg::symbolT   symbol,
    input  codecPkg::intervalT curInterval,
    output logic               updDone,
    output codecPkg::intervalT newInterval
);

    import codecPkg::*;

    localparam int freqWidth = $clog2(`FREQ_TOTAL + 1);

    updStateT                    state;
    logic [freqWidth:0]          symTimesNext;    // k*(k+1), halved for the begin
    logic [freqWidth-1:0]        cumBegin;
    logic [freqWidth-1:0]        cumEnd;
    logic [`CODEC_PRECISION-1:0] width;
    logic [`PRODUCT_WIDTH-1:0]   beginProduct;
    logic [`PRODUCT_WIDTH-1:0]   endProduct;
    logic [`PRODUCT_WIDTH-1:0]   beginProductReg;
    logic [`PRODUCT_WIDTH-1:0]   endProductReg;
    logic [`CODEC_PRECISION-1:0] baseLow;
    logic                        divStart;
    logic                        divDone;
    logic [`PRODUCT_WIDTH-1:0]   dividend;
    logic [`PRODUCT_WIDTH-1:0]   quotient;

    // model rule, begin of k is k(k+1)/2 and EOF closes at the total
    assign symTimesNext = (freqWidth + 1)'(symbol) * ((freqWidth + 1)'(symbol) + 1'b1);
    assign cumBegin = symTimesNext[freqWidth:1];
    assign cumEnd = (symbol == `EOF_SYMBOL) ? freqWidth'(`FREQ_TOTAL)
                                            : cumBegin + freqWidth'(symbol) + 1'b1;

    assign width = curInterval.high - curInterval.low;
    assign beginProduct = width * cumBegin;
    assign endProduct = width * cumEnd;

    assign dividend = (state == UPD_LOW) ? beginProductReg : endProductReg;
    assign updDone = (state == UPD_DONE);

    totalDivider divider (
        .clk      (clk),
        .rstn     (rstn),
        .divStart (divStart),
        .dividend (dividend),
        .divDone  (divDone),
        .quotient (quotient)
    );

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= UPD_IDLE;
            divStart <= 1'b0;
        end else begin
            divStart <= 1'b0;
            case (state)
                UPD_IDLE: begin
                    if (updStart) begin
                        state <= UPD_HIGH;
                        divStart <= 1'b1;    // end product goes first
                    end
                end
                UPD_HIGH: begin
                    if (divDone) begin
                        state <= UPD_LOW;
                        divStart <= 1'b1;
                    end
                end
                UPD_LOW: begin
                    if (divDone) begin
                        state <= UPD_DONE;
                    end
                end
                default: state <= UPD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == UPD_IDLE && updStart) begin
            beginProductReg <= beginProduct;
            endProductReg <= endProduct;
            baseLow <= curInterval.low;    // both bounds offset from the old low
        end
        if (state == UPD_HIGH && divDone) begin
            newInterval.high <= baseLow + quotient[`CODEC_PRECISION-1:0];
        end
        if (state == UPD_LOW && divDone) begin
            newInterval.low <= baseLow + quotient[`CODEC_PRECISION-1:0];
        end
    end

    assert property (@(posedge clk) disable iff (!rstn) updStart |-> symbol < `NUM_SYMBOLS)
        else $error("symbol outside the model alphabet");

endmodule

//--- verilog/totalDivider.sv
// serial restoring divider, one quotient bit per cycle, divisor fixed at the model total
`timescale 1ns/100ps
`include "codec_defs.svh"

module totalDivider (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      divStart,
    input  logic [`PRODUCT_WIDTH-1:0] dividend,
    output logic                      divDone,
    output logic [`PRODUCT_WIDTH-1:0] quotient
);

    localparam int remWidth = $clog2(`FREQ_TOTAL);
    localparam int countWidth = $clog2(`PRODUCT_WIDTH + 1);
    localparam logic [remWidth:0] divisor = `FREQ_TOTAL;

    logic                      busy;
    logic [countWidth-1:0]     bitsLeft;
    logic [remWidth-1:0]       remainder;    // always below the divisor
    logic [`PRODUCT_WIDTH-1:0] shiftReg;     // dividend out at the top, quotient in at the bottom
    logic [remWidth:0]         trial;

    assign trial = {remainder, shiftReg[`PRODUCT_WIDTH-1]};
    assign quotient = shiftReg;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy <= 1'b0;
            divDone <= 1'b0;
            bitsLeft <= '0;
        end else begin
            divDone <= 1'b0;
            if (divStart) begin
                busy <= 1'b1;
                bitsLeft <= countWidth'(`PRODUCT_WIDTH);
            end else if (busy) begin
                bitsLeft <= bitsLeft - 1'b1;
                if (bitsLeft == countWidth'(1)) begin    // last quotient bit this cycle
                    busy <= 1'b0;
                    divDone <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (divStart) begin
            remainder <= '0;
            shiftReg <= dividend;
        end else if (busy) begin
            if (trial >= divisor) begin
                remainder <= remWidth'(trial - divisor);
                shiftReg <= {shiftReg[`PRODUCT_WIDTH-2:0], 1'b1};
            end else begin
                remainder <= trial[remWidth-1:0];    // restore, keep the partial remainder
                shiftReg <= {shiftReg[`PRODUCT_WIDTH-2:0], 1'b0};
            end
        end
    end

    // the caller keeps only one division in flight
    assert property (@(posedge clk) disable iff (!rstn) divStart |-> !busy)
        else $error("divider started while a division is running");

endmodule

//--- verilog/codecPkg.sv
// shared types for the arithmetic encoder datapath and control
`include "codec_defs.svh"

package codecPkg;

    typedef logic [$clog2(`NUM_SYMBOLS)-1:0] symbolT;

    // current coding interval, high is exclusive
    typedef struct packed {
        logic [`CODEC_PRECISION-1:0] high;
        logic [`CODEC_PRECISION-1:0] low;
    } intervalT;

    // one emitted code bit, valid for a single cycle
    typedef struct packed {
        logic valid;
        logic value;
    } codeBitT;

    typedef enum logic [2:0] {
        ENC_IDLE,
        ENC_UPDATE,
        ENC_RENORM,
        ENC_REQUEST,
        ENC_WAIT_DROP,
        ENC_FINISH
    } encStateT;

    typedef enum logic [1:0] {
        RN_IDLE,
        RN_DECIDE,
        RN_PENDING,
        RN_DRAIN
    } renormStateT;

    typedef enum logic [1:0] {
        UPD_IDLE,
        UPD_HIGH,
        UPD_LOW,
        UPD_DONE
    } updStateT;

endpackage

//--- verilog/codec_defs.svh
// codec constants for interval precision, model alphabet and output word size
`ifndef CODEC_DEFS_SVH
`define CODEC_DEFS_SVH

// interval register width and its fixed split points
`define CODEC_PRECISION 24
`define CODEC_WHOLE (1 << (`CODEC_PRECISION - 1))
`define CODEC_HALF (1 << (`CODEC_PRECISION - 2))
`define CODEC_QUARTER (1 << (`CODEC_PRECISION - 3))
`define CODEC_THREE_QUARTERS (3 << (`CODEC_PRECISION - 3))

// model alphabet, symbol k has frequency k+1 and EOF has frequency 1
`define NUM_SYMBOLS 17
`define EOF_SYMBOL 16
`define FREQ_TOTAL 137

// datapath and output sizes
`define PRODUCT_WIDTH 32
`define WORD_BITS 32
`define PENDING_WIDTH 7

`endif
